// ==== source/tiler_settings.svh ====
`ifndef TILER_SETTINGS_SVH
`define TILER_SETTINGS_SVH

// Pixel and image geometry
`define TILER_PIXEL_W       8
`define TILER_CHANNELS      3
`define TILER_IMG_WIDTH     10

// Tile geometry, stride applies in both directions
`define TILER_TILE_SIZE     4
`define TILER_STRIDE        2

// Derived sizes
`define TILER_NUM_LINES     (`TILER_TILE_SIZE + `TILER_STRIDE)
`define TILER_LINE_DEPTH    (`TILER_CHANNELS * `TILER_IMG_WIDTH)
`define TILER_TILES_PER_ROW (((`TILER_IMG_WIDTH - `TILER_TILE_SIZE) / `TILER_STRIDE) + 1)

`endif

// ==== source/tiler_pkg.sv ====
`include "tiler_settings.svh"

package tiler_pkg;

    typedef logic [`TILER_PIXEL_W-1:0] pixel_t;

    // Ring slot number and tile start column
    typedef logic [$clog2(`TILER_NUM_LINES)-1:0] line_idx_t;
    typedef logic [$clog2(`TILER_IMG_WIDTH)-1:0] col_idx_t;

    // Window of one row, channel 0 in the low bytes
    typedef logic [`TILER_CHANNELS*`TILER_TILE_SIZE*`TILER_PIXEL_W-1:0] row_data_t;

    // Column fastest, then tile row, then channel
    typedef logic [`TILER_CHANNELS*`TILER_TILE_SIZE*`TILER_TILE_SIZE*`TILER_PIXEL_W-1:0] tile_t;

    typedef enum logic {FILL_PRIME, FILL_STEADY} fill_state_e;
    typedef enum logic {RD_IDLE, RD_ACTIVE} rd_state_e;

endpackage

// ==== source/row_buffer.sv ====
`timescale 1ns/1ps
`include "tiler_settings.svh"

module row_buffer (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_wr_en,
    input  tiler_pkg::pixel_t    i_pixel,
    input  logic                 i_rd_en,
    input  tiler_pkg::col_idx_t  i_rd_col,
    output tiler_pkg::row_data_t o_row_data
);

    localparam int ADDR_W = $clog2(`TILER_LINE_DEPTH);

    tiler_pkg::pixel_t mem [`TILER_LINE_DEPTH];
    logic [ADDR_W-1:0] wr_addr;

    // Write address walks through all channels of the row, then wraps
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            wr_addr <= '0;
        end else if (i_wr_en) begin
            if (wr_addr == ADDR_W'(`TILER_LINE_DEPTH - 1)) begin
                wr_addr <= '0;
            end else begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[wr_addr] <= i_pixel;
        end
    end

    // Tile-size pixels from each channel segment, starting at the column
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            for (int ch = 0; ch < `TILER_CHANNELS; ch++) begin
                for (int px = 0; px < `TILER_TILE_SIZE; px++) begin
                    o_row_data[(ch*`TILER_TILE_SIZE + px)*`TILER_PIXEL_W +: `TILER_PIXEL_W] <=
                        mem[ch*`TILER_IMG_WIDTH + int'(i_rd_col) + px];
                end
            end
        end
    end

endmodule

// ==== source/line_fill_control.sv ====
`timescale 1ns/1ps
`include "tiler_settings.svh"

module line_fill_control (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic                         i_pixel_valid,
    output logic [`TILER_NUM_LINES-1:0]  o_wr_en,
    output logic                         o_group_done,
    output tiler_pkg::line_idx_t         o_top_line
);

    localparam int PIX_W = $clog2(`TILER_LINE_DEPTH);
    localparam int ROW_W = $clog2(`TILER_TILE_SIZE + 1);

    tiler_pkg::fill_state_e state;
    logic [PIX_W-1:0]       pix_cnt;
    logic [ROW_W-1:0]       row_cnt;
    logic [ROW_W-1:0]       rows_needed;
    tiler_pkg::line_idx_t   wr_line;
    tiler_pkg::line_idx_t   top_next;
    logic                   row_end;
    logic                   group_end;

    assign row_end = i_pixel_valid && (pix_cnt == PIX_W'(`TILER_LINE_DEPTH - 1));

    // Priming needs a full tile of rows, afterwards one stride at a time
    assign rows_needed = (state == tiler_pkg::FILL_PRIME) ? ROW_W'(`TILER_TILE_SIZE)
                                                          : ROW_W'(`TILER_STRIDE);
    assign group_end = row_end && (row_cnt == rows_needed - 1'b1);

    // Only the slot being filled sees the strobe
    always_comb begin
        o_wr_en = '0;
        if (i_pixel_valid) begin
            o_wr_en[wr_line] = 1'b1;
        end
    end

    // Oldest row of the group, tile-size minus one slots back
    always_comb begin
        if (wr_line >= tiler_pkg::line_idx_t'(`TILER_TILE_SIZE - 1)) begin
            top_next = wr_line - tiler_pkg::line_idx_t'(`TILER_TILE_SIZE - 1);
        end else begin
            top_next = wr_line + tiler_pkg::line_idx_t'(`TILER_NUM_LINES - `TILER_TILE_SIZE + 1);
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state        <= tiler_pkg::FILL_PRIME;
            pix_cnt      <= '0;
            row_cnt      <= '0;
            wr_line      <= '0;
            o_group_done <= 1'b0;
            o_top_line   <= '0;
        end else begin
            o_group_done <= group_end;
            if (row_end) begin
                pix_cnt <= '0;
                if (wr_line == tiler_pkg::line_idx_t'(`TILER_NUM_LINES - 1)) begin
                    wr_line <= '0;
                end else begin
                    wr_line <= wr_line + 1'b1;
                end
                if (group_end) begin
                    row_cnt    <= '0;
                    state      <= tiler_pkg::FILL_STEADY;
                    o_top_line <= top_next;
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end else if (i_pixel_valid) begin
                pix_cnt <= pix_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== source/tile_reader.sv ====
`timescale 1ns/1ps
`include "tiler_settings.svh"

module tile_reader (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_group_done,
    input  tiler_pkg::line_idx_t i_top_line,
    output logic                 o_rd_en,
    output tiler_pkg::col_idx_t  o_rd_col,
    output logic                 o_data_valid,
    output tiler_pkg::line_idx_t o_data_top_line
);

    localparam int CNT_W = $clog2(`TILER_TILES_PER_ROW + 1);

    tiler_pkg::rd_state_e state;
    logic [CNT_W-1:0]     tile_cnt;
    tiler_pkg::line_idx_t top_line_q;

    assign o_rd_en = (state == tiler_pkg::RD_ACTIVE);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state           <= tiler_pkg::RD_IDLE;
            tile_cnt        <= '0;
            top_line_q      <= '0;
            o_rd_col        <= '0;
            o_data_valid    <= 1'b0;
            o_data_top_line <= '0;
        end else begin
            // Row buffer data lags the read by one cycle
            o_data_valid    <= o_rd_en;
            o_data_top_line <= top_line_q;
            case (state)
                tiler_pkg::RD_IDLE: begin
                    if (i_group_done) begin
                        state      <= tiler_pkg::RD_ACTIVE;
                        top_line_q <= i_top_line;
                        tile_cnt   <= '0;
                        o_rd_col   <= '0;
                    end
                end
                tiler_pkg::RD_ACTIVE: begin
                    if (tile_cnt == CNT_W'(`TILER_TILES_PER_ROW - 1)) begin
                        state <= tiler_pkg::RD_IDLE;
                    end else begin
                        tile_cnt <= tile_cnt + 1'b1;
                        o_rd_col <= o_rd_col + tiler_pkg::col_idx_t'(`TILER_STRIDE);
                    end
                end
                default: begin
                    state <= tiler_pkg::RD_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== source/tile_assembler.sv ====
`timescale 1ns/1ps
`include "tiler_settings.svh"

module tile_assembler (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_data_valid,
    input  tiler_pkg::line_idx_t i_data_top_line,
    input  tiler_pkg::row_data_t i_row_data [`TILER_NUM_LINES],
    output tiler_pkg::tile_t     o_tile,
    output logic                 o_tile_valid
);

    tiler_pkg::tile_t tile_next;

    // Ring slot holding tile row r
    function automatic tiler_pkg::line_idx_t slot_of(input tiler_pkg::line_idx_t top,
                                                     input int r);
        int s;
        s = int'(top) + r;
        if (s >= `TILER_NUM_LINES) begin
            s = s - `TILER_NUM_LINES;
        end
        return tiler_pkg::line_idx_t'(s);
    endfunction

    // Channel-major slices of each row become column-fastest tile bytes
    always_comb begin
        tile_next = '0;
        for (int ch = 0; ch < `TILER_CHANNELS; ch++) begin
            for (int r = 0; r < `TILER_TILE_SIZE; r++) begin
                for (int c = 0; c < `TILER_TILE_SIZE; c++) begin
                    tile_next[((ch*`TILER_TILE_SIZE + r)*`TILER_TILE_SIZE + c)*`TILER_PIXEL_W
                              +: `TILER_PIXEL_W] =
                        i_row_data[slot_of(i_data_top_line, r)]
                                  [(ch*`TILER_TILE_SIZE + c)*`TILER_PIXEL_W +: `TILER_PIXEL_W];
                end
            end
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_tile       <= '0;
            o_tile_valid <= 1'b0;
        end else begin
            o_tile_valid <= i_data_valid;
            if (i_data_valid) begin
                o_tile <= tile_next;
            end
        end
    end

endmodule

// ==== source/conv_tile_extractor.sv ====
`timescale 1ns/1ps
`include "tiler_settings.svh"

module conv_tile_extractor (
    input  logic              i_clk,
    input  logic              i_rst,
    input  tiler_pkg::pixel_t i_pixel,
    input  logic              i_pixel_valid,
    output tiler_pkg::tile_t  o_tile,
    output logic              o_tile_valid
);

    logic [`TILER_NUM_LINES-1:0] wr_en;
    logic                        group_done;
    tiler_pkg::line_idx_t        top_line;
    logic                        rd_en;
    tiler_pkg::col_idx_t         rd_col;
    logic                        data_valid;
    tiler_pkg::line_idx_t        data_top_line;
    tiler_pkg::row_data_t        row_data [`TILER_NUM_LINES];

    line_fill_control i_line_fill_control (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_pixel_valid (i_pixel_valid),
        .o_wr_en       (wr_en),
        .o_group_done  (group_done),
        .o_top_line    (top_line)
    );

    // Ring of row buffers, all read at the same column
    for (genvar g = 0; g < `TILER_NUM_LINES; g++) begin : g_ring
        row_buffer i_row_buffer (
            .i_clk      (i_clk),
            .i_rst      (i_rst),
            .i_wr_en    (wr_en[g]),
            .i_pixel    (i_pixel),
            .i_rd_en    (rd_en),
            .i_rd_col   (rd_col),
            .o_row_data (row_data[g])
        );
    end

    tile_reader i_tile_reader (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_group_done    (group_done),
        .i_top_line      (top_line),
        .o_rd_en         (rd_en),
        .o_rd_col        (rd_col),
        .o_data_valid    (data_valid),
        .o_data_top_line (data_top_line)
    );

    tile_assembler i_tile_assembler (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_data_valid    (data_valid),
        .i_data_top_line (data_top_line),
        .i_row_data      (row_data),
        .o_tile          (o_tile),
        .o_tile_valid    (o_tile_valid)
    );

endmodule

// ==== tests/tile_extractor_asserts.sv ====
`timescale 1ns/1ps
`include "tiler_settings.svh"

module tile_extractor_asserts (
    input logic                        i_clk,
    input logic                        i_rst,
    input logic [`TILER_NUM_LINES-1:0] i_wr_en,
    input logic                        i_group_done,
    input logic                        i_rd_en,
    input logic                        i_tile_valid
);

    int valid_run;

    // Length of the current run of valid tiles
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            valid_run <= 0;
        end else if (i_tile_valid) begin
            valid_run <= valid_run + 1;
        end else begin
            valid_run <= 0;
        end
    end

    a_one_slot_written: assert property (@(posedge i_clk) disable iff (i_rst)
        $onehot0(i_wr_en))
        else $error("More than one row buffer written in the same cycle");

    // Reader must be done before the next group of rows completes
    a_group_when_idle: assert property (@(posedge i_clk) disable iff (i_rst)
        i_group_done |-> !i_rd_en)
        else $error("Group completed while the tile reader was still active");

    a_valid_run_length: assert property (@(posedge i_clk) disable iff (i_rst)
        i_tile_valid |-> valid_run < `TILER_TILES_PER_ROW)
        else $error("Tile valid held longer than one group of tiles");

endmodule

bind conv_tile_extractor tile_extractor_asserts i_tile_extractor_asserts (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_wr_en      (wr_en),
    .i_group_done (group_done),
    .i_rd_en      (rd_en),
    .i_tile_valid (o_tile_valid)
);

// ==== tests/tb_conv_tile_extractor.sv ====
`timescale 1ns/1ps
`include "tiler_settings.svh"

module tb_conv_tile_extractor;

    localparam int PW     = `TILER_PIXEL_W;
    localparam int TS     = `TILER_TILE_SIZE;
    localparam int STRIDE = `TILER_STRIDE;
    localparam int DEPTH  = `TILER_LINE_DEPTH;
    localparam int TPR    = `TILER_TILES_PER_ROW;
    // About 40 rows in all, each allowed four times its length for gaps and waits
    localparam int TIMEOUT_CYCLES = 40 * 4 * DEPTH + 200;

    logic              i_clk;
    logic              i_rst;
    tiler_pkg::pixel_t i_pixel;
    logic              i_pixel_valid;
    tiler_pkg::tile_t  o_tile;
    logic              o_tile_valid;

    tiler_pkg::pixel_t hist [$];
    tiler_pkg::tile_t  got_tiles [$];
    int                got_cycles [$];
    int                tile_base;
    int                cycle;
    int                last_drive_cycle;
    int                error_count;
    int                tests_run;
    int                tests_failed;

    conv_tile_extractor i_conv_tile_extractor (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_pixel       (i_pixel),
        .i_pixel_valid (i_pixel_valid),
        .o_tile        (o_tile),
        .o_tile_valid  (o_tile_valid)
    );

    always #4 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // Every tile seen, with the cycle it was sampled in
    always @(posedge i_clk) begin
        if (o_tile_valid === 1'b1) begin
            got_tiles.push_back(o_tile);
            got_cycles.push_back(cycle);
        end
    end

    // Rows top_row and below, channel by channel, columns col and to the right
    function automatic tiler_pkg::tile_t expected_tile(input int top_row, input int col);
        tiler_pkg::tile_t t;
        t = '0;
        for (int ch = 0; ch < `TILER_CHANNELS; ch++) begin
            for (int r = 0; r < TS; r++) begin
                for (int c = 0; c < TS; c++) begin
                    t[((ch*TS + r)*TS + c)*PW +: PW] =
                        hist[(top_row + r)*DEPTH + ch*`TILER_IMG_WIDTH + col + c];
                end
            end
        end
        return t;
    endfunction

    // Five cycles of reset, then two more cycles of outputs checked if asked
    task automatic apply_reset(input bit check_outputs);
        @(posedge i_clk);
        i_rst         <= 1'b1;
        i_pixel_valid <= 1'b0;
        i_pixel       <= '0;
        for (int i = 0; i < 7; i++) begin
            @(posedge i_clk);
            if (i == 4) begin
                i_rst <= 1'b0;
            end
            if (check_outputs && (o_tile_valid !== 1'b0 || o_tile !== '0)) begin
                $display("Error at time %0t: outputs not cleared, cycle %0d of reset test",
                         $time, i + 1);
                error_count++;
            end
        end
        hist.delete();
        tile_base = got_tiles.size();
    endtask

    task automatic send_pixels(input int count, input bit gaps);
        tiler_pkg::pixel_t px;
        for (int i = 0; i < count; i++) begin
            while (gaps && $urandom_range(2) == 0) begin
                @(posedge i_clk);
                i_pixel_valid <= 1'b0;
            end
            px = tiler_pkg::pixel_t'($urandom);
            @(posedge i_clk);
            i_pixel       <= px;
            i_pixel_valid <= 1'b1;
            hist.push_back(px);
            last_drive_cycle = cycle;
        end
    endtask

    // Ends the stream, waits for the groups and compares every tile since the last call
    task automatic check_groups(input int num_groups);
        int waited;
        int idx;
        tiler_pkg::tile_t exp;
        waited = 0;
        @(posedge i_clk);
        i_pixel_valid <= 1'b0;
        while (got_tiles.size() - tile_base < num_groups * TPR && waited < 64) begin
            @(posedge i_clk);
            waited++;
        end
        // Surplus tiles would show up here
        repeat (8) @(posedge i_clk);
        if (got_tiles.size() - tile_base != num_groups * TPR) begin
            $display("Error at time %0t: expected %0d tiles, got %0d", $time,
                     num_groups * TPR, got_tiles.size() - tile_base);
            error_count++;
        end
        for (int g = 0; g < num_groups; g++) begin
            for (int t = 0; t < TPR; t++) begin
                idx = tile_base + g*TPR + t;
                exp = expected_tile(g*STRIDE, t*STRIDE);
                if (idx < got_tiles.size() && got_tiles[idx] !== exp) begin
                    $display("Error at time %0t: group %0d, tile at column %0d has wrong data",
                             $time, g, t*STRIDE);
                    error_count++;
                end
            end
        end
        tile_base = got_tiles.size();
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (error_count == errs_before) begin
            $display("PASS: %s", name);
        end else begin
            tests_failed++;
            $display("FAIL: %s, %0d errors", name, error_count - errs_before);
        end
    endtask

    task automatic test_reset_state();
        int errs;
        errs = error_count;
        apply_reset(1'b1);
        report_test("reset state", errs);
    endtask

    task automatic test_priming();
        int errs;
        errs = error_count;
        apply_reset(1'b0);
        send_pixels((TS - 1) * DEPTH, 1'b0);
        check_groups(0);
        send_pixels(DEPTH, 1'b0);
        check_groups(1);
        report_test("priming", errs);
    endtask

    task automatic test_fixed_latency();
        int errs;
        int edge_e;
        errs = error_count;
        apply_reset(1'b0);
        send_pixels(TS * DEPTH, 1'b0);
        // The last pixel is taken at the edge after it was driven
        edge_e = last_drive_cycle + 1;
        send_pixels(DEPTH, 1'b0);
        for (int i = 0; i < TPR; i++) begin
            // Valid rises after edge E+3, the monitor first samples it at E+4
            if (tile_base + i >= got_cycles.size() ||
                got_cycles[tile_base + i] != edge_e + 4 + i) begin
                $display("Error at time %0t: tile %0d not seen at cycle %0d", $time, i,
                         edge_e + 4 + i);
                error_count++;
            end
        end
        check_groups(1);
        report_test("fixed latency", errs);
    endtask

    task automatic test_ring_wrap();
        int errs;
        errs = error_count;
        apply_reset(1'b0);
        send_pixels(12 * DEPTH, 1'b0);
        check_groups(5);
        report_test("steady state across ring wrap", errs);
    endtask

    task automatic test_gapped_input();
        int errs;
        errs = error_count;
        apply_reset(1'b0);
        send_pixels(8 * DEPTH, 1'b1);
        check_groups(3);
        report_test("gapped input", errs);
    endtask

    task automatic test_reset_mid_stream();
        int errs;
        errs = error_count;
        apply_reset(1'b0);
        send_pixels(5 * DEPTH + DEPTH / 2, 1'b0);
        apply_reset(1'b0);
        send_pixels((TS - 1) * DEPTH, 1'b0);
        check_groups(0);
        send_pixels(DEPTH, 1'b0);
        check_groups(1);
        report_test("reset mid-stream", errs);
    endtask

    initial begin
        i_clk         = 1'b0;
        i_rst         = 1'b0;
        i_pixel       = '0;
        i_pixel_valid = 1'b0;
        error_count   = 0;
        tests_run     = 0;
        tests_failed  = 0;
        tile_base     = 0;
        void'($urandom(6948));
        test_reset_state();
        test_priming();
        test_fixed_latency();
        test_ring_wrap();
        test_gapped_input();
        test_reset_mid_stream();
        $display("%0d tests run, %0d passed, %0d failed, %0d errors", tests_run,
                 tests_run - tests_failed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+source
source/tiler_pkg.sv
source/row_buffer.sv
source/line_fill_control.sv
source/tile_reader.sv
source/tile_assembler.sv
source/conv_tile_extractor.sv
tests/tile_extractor_asserts.sv
tests/tb_conv_tile_extractor.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_conv_tile_extractor
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f sources.f
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
